/* src/gc_params.svh */
`ifndef GC_PARAMS_SVH
`define GC_PARAMS_SVH

// Region sizes in 32-bit words
`define GC_CODE_WORDS   64
`define GC_G_WORDS      64
`define GC_E_WORDS      64
`define GC_OUT_WORDS    64
`define GC_STACK_WORDS  64

// Region numbers, matched against address bits 31:24
`define GC_REGION_CODE  8'd0  // 0x00000000
`define GC_REGION_G     8'd1  // Garbler input
`define GC_REGION_E     8'd2  // Evaluator input
`define GC_REGION_OUT   8'd3
`define GC_REGION_STACK 8'd4

`define GC_NUM_REGS     8     // r0 is a normal register

`endif

/* src/gc_pkg.sv */
`default_nettype none

package gc_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;     // Byte address
  typedef logic [2:0]  reg_idx_t;
  typedef logic [3:0]  byte_en_t;  // All ones or one-hot

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_ADDI = 4'd5,
    OP_LUI  = 4'd6,
    OP_LDW  = 4'd7,
    OP_STW  = 4'd8,
    OP_STB  = 4'd9,
    OP_BNE  = 4'd10,
    OP_HALT = 4'd11
  } opcode_e;

  typedef enum logic [1:0] {
    FETCH  = 2'd0,
    EXEC   = 2'd1,
    HALTED = 2'd2
  } core_state_e;

  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;     // Sign-extended imm16
  } decoded_t;

  typedef struct packed {
    addr_t    addr;
    word_t    wdata;
    logic     we;
    byte_en_t be;
  } mem_req_t;

endpackage

`default_nettype wire

/* src/gc_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module gc_decode (
  input  gc_pkg::word_t    i_instr,
  output gc_pkg::decoded_t o_dec
);

  import gc_pkg::*;

  logic [3:0] op_bits;
  logic [15:0] imm16;

  assign op_bits = i_instr[31:28];
  assign imm16   = i_instr[15:0];

  always_comb begin
    o_dec.rd  = i_instr[27:25];
    o_dec.rs1 = i_instr[24:22];
    o_dec.rs2 = i_instr[21:19];
    o_dec.imm = {{16{imm16[15]}}, imm16};

    case (op_bits)
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_ADDI,
      OP_LUI,
      OP_LDW,
      OP_STW,
      OP_STB,
      OP_BNE:  o_dec.opcode = opcode_e'(op_bits);
      // Codes 12 to 15 stop the core
      default: o_dec.opcode = OP_HALT;
    endcase
  end

endmodule

`default_nettype wire

/* src/gc_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module gc_execute (
  input  gc_pkg::decoded_t i_dec,
  input  gc_pkg::word_t    i_rs1_val,
  input  gc_pkg::word_t    i_rs2_val,
  input  gc_pkg::word_t    i_pc,
  output gc_pkg::word_t    o_alu,
  output gc_pkg::addr_t    o_addr,
  output gc_pkg::addr_t    o_next_pc
);

  import gc_pkg::*;

  logic  taken;
  addr_t seq_pc;
  addr_t branch_off;

  always_comb begin
    case (i_dec.opcode)
      OP_ADD:  o_alu = i_rs1_val + i_rs2_val;
      OP_SUB:  o_alu = i_rs1_val - i_rs2_val;
      OP_AND:  o_alu = i_rs1_val & i_rs2_val;
      OP_OR:   o_alu = i_rs1_val | i_rs2_val;
      OP_XOR:  o_alu = i_rs1_val ^ i_rs2_val;
      OP_ADDI: o_alu = i_rs1_val + i_dec.imm;
      OP_LUI:  o_alu = {i_dec.imm[15:0], 16'h0000};  // Low half cleared
      default: o_alu = '0;
    endcase
  end

  // Loads and stores share base plus offset
  assign o_addr = i_rs1_val + i_dec.imm;

  assign taken      = (i_dec.opcode == OP_BNE) && (i_rs1_val != i_rs2_val);
  assign seq_pc     = i_pc + 32'd4;
  assign branch_off = {i_dec.imm[29:0], 2'b00};  // Offset in words
  assign o_next_pc  = taken ? seq_pc + branch_off : seq_pc;

endmodule

`default_nettype wire

/* src/gc_result.sv */
`timescale 1ns/1ps
`default_nettype none

module gc_result (
  input  gc_pkg::decoded_t i_dec,
  input  gc_pkg::word_t    i_alu,
  input  gc_pkg::word_t    i_rs2_val,
  input  gc_pkg::word_t    i_rdata,
  input  gc_pkg::addr_t    i_addr,
  output gc_pkg::mem_req_t o_req,
  output logic             o_wb_en,
  output gc_pkg::reg_idx_t o_wb_idx,
  output gc_pkg::word_t    o_wb_val
);

  import gc_pkg::*;

  logic [1:0] lane;
  word_t      byte_word;

  assign lane      = i_addr[1:0];
  assign byte_word = word_t'(i_rs2_val[7:0]) << {lane, 3'b000};

  always_comb begin
    o_req.addr  = i_addr;
    o_req.wdata = i_rs2_val;
    o_req.we    = 1'b0;
    o_req.be    = 4'b1111;
    case (i_dec.opcode)
      OP_STW: o_req.we = 1'b1;
      OP_STB: begin
        o_req.we    = 1'b1;
        o_req.wdata = byte_word;  // Byte moved into its lane
        o_req.be    = byte_en_t'(4'b0001) << lane;
      end
      default: o_req.we = 1'b0;   // LDW reads through the same address
    endcase
  end

  always_comb begin
    case (i_dec.opcode)
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_ADDI,
      OP_LUI,
      OP_LDW:  o_wb_en = 1'b1;
      default: o_wb_en = 1'b0;
    endcase
  end

  assign o_wb_idx = i_dec.rd;
  assign o_wb_val = (i_dec.opcode == OP_LDW) ? i_rdata : i_alu;

endmodule

`default_nettype wire

/* src/gc_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gc_params.svh"

module gc_core (
  input  logic             clk,
  input  logic             rst,
  output gc_pkg::mem_req_t o_req,
  input  gc_pkg::word_t    i_rdata,
  output logic             o_terminate
);

  import gc_pkg::*;

  core_state_e state;
  addr_t       pc;
  word_t       ir;
  word_t       regs [`GC_NUM_REGS];
  decoded_t    dec;
  word_t       alu;
  addr_t       ex_addr;
  addr_t       next_pc;
  mem_req_t    ex_req;
  logic        wb_en;
  reg_idx_t    wb_idx;
  word_t       wb_val;

  gc_decode u_gc_decode (
    .i_instr (ir),
    .o_dec   (dec)
  );

  gc_execute u_gc_execute (
    .i_dec     (dec),
    .i_rs1_val (regs[dec.rs1]),
    .i_rs2_val (regs[dec.rs2]),
    .i_pc      (pc),
    .o_alu     (alu),
    .o_addr    (ex_addr),
    .o_next_pc (next_pc)
  );

  gc_result u_gc_result (
    .i_dec     (dec),
    .i_alu     (alu),
    .i_rs2_val (regs[dec.rs2]),
    .i_rdata   (i_rdata),
    .i_addr    (ex_addr),
    .o_req     (ex_req),
    .o_wb_en   (wb_en),
    .o_wb_idx  (wb_idx),
    .o_wb_val  (wb_val)
  );

  always_comb begin
    if (state == EXEC) begin
      o_req = ex_req;
    end else begin
      o_req.addr  = pc;     // Instruction fetch or idle read when halted
      o_req.wdata = '0;
      o_req.we    = 1'b0;
      o_req.be    = 4'b1111;
    end
  end

  assign o_terminate = (state == HALTED);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= FETCH;
      pc    <= '0;
      for (int i = 0; i < `GC_NUM_REGS; i++)
        regs[i] <= '0;
    end else begin
      case (state)
        FETCH: state <= EXEC;
        EXEC: begin
          if (wb_en)
            regs[wb_idx] <= wb_val;
          pc    <= next_pc;
          state <= (dec.opcode == OP_HALT) ? HALTED : FETCH;
        end
        default: state <= HALTED;  // Frozen until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FETCH)
      ir <= i_rdata;
  end

endmodule

`default_nettype wire

/* src/gc_mem_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gc_params.svh"

module gc_mem_map (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`GC_CODE_WORDS*32-1:0]  i_code_init,
  input  logic [`GC_G_WORDS*32-1:0]     i_g_init,
  input  logic [`GC_E_WORDS*32-1:0]     i_e_init,
  input  gc_pkg::mem_req_t              i_req,
  output gc_pkg::word_t                 o_rdata,
  output logic [`GC_OUT_WORDS*32-1:0]   o_out
);

  localparam int CODE_AW  = $clog2(4*`GC_CODE_WORDS);
  localparam int G_AW     = $clog2(4*`GC_G_WORDS);
  localparam int E_AW     = $clog2(4*`GC_E_WORDS);
  localparam int OUT_AW   = $clog2(4*`GC_OUT_WORDS);
  localparam int STACK_AW = $clog2(4*`GC_STACK_WORDS);

  logic [7:0] code_mem  [4*`GC_CODE_WORDS];
  logic [7:0] g_mem     [4*`GC_G_WORDS];
  logic [7:0] e_mem     [4*`GC_E_WORDS];
  logic [7:0] out_mem   [4*`GC_OUT_WORDS];
  logic [7:0] stack_mem [4*`GC_STACK_WORDS];

  logic [7:0]          region;
  logic [CODE_AW-1:0]  code_idx;
  logic [G_AW-1:0]     g_idx;
  logic [E_AW-1:0]     e_idx;
  logic [OUT_AW-1:0]   out_idx;
  logic [STACK_AW-1:0] stack_idx;

  assign region = i_req.addr[31:24];

  // Word aligned byte offsets within each region
  assign code_idx  = {i_req.addr[CODE_AW-1:2], 2'b00};
  assign g_idx     = {i_req.addr[G_AW-1:2], 2'b00};
  assign e_idx     = {i_req.addr[E_AW-1:2], 2'b00};
  assign out_idx   = {i_req.addr[OUT_AW-1:2], 2'b00};
  assign stack_idx = {i_req.addr[STACK_AW-1:2], 2'b00};

  // Little-endian word read with zero for unmapped regions
  always_comb begin
    o_rdata = '0;
    for (int k = 0; k < 4; k++) begin
      case (region)
        `GC_REGION_CODE:  o_rdata[8*k +: 8] = code_mem[code_idx + k];
        `GC_REGION_G:     o_rdata[8*k +: 8] = g_mem[g_idx + k];
        `GC_REGION_E:     o_rdata[8*k +: 8] = e_mem[e_idx + k];
        `GC_REGION_OUT:   o_rdata[8*k +: 8] = out_mem[out_idx + k];
        `GC_REGION_STACK: o_rdata[8*k +: 8] = stack_mem[stack_idx + k];
        default:          o_rdata[8*k +: 8] = 8'h00;
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < 4*`GC_OUT_WORDS; i++)
      o_out[8*i +: 8] = out_mem[i];
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 4*`GC_CODE_WORDS; i++)
        code_mem[i] <= i_code_init[8*i +: 8];
      for (int i = 0; i < 4*`GC_G_WORDS; i++)
        g_mem[i] <= i_g_init[8*i +: 8];
      for (int i = 0; i < 4*`GC_E_WORDS; i++)
        e_mem[i] <= i_e_init[8*i +: 8];
      for (int i = 0; i < 4*`GC_OUT_WORDS; i++)
        out_mem[i] <= 8'h00;
      for (int i = 0; i < 4*`GC_STACK_WORDS; i++)
        stack_mem[i] <= 8'h00;
    end else if (i_req.we) begin
      for (int k = 0; k < 4; k++) begin
        if (i_req.be[k]) begin
          case (region)
            `GC_REGION_CODE:  code_mem[code_idx + k]   <= i_req.wdata[8*k +: 8];
            `GC_REGION_OUT:   out_mem[out_idx + k]     <= i_req.wdata[8*k +: 8];
            `GC_REGION_STACK: stack_mem[stack_idx + k] <= i_req.wdata[8*k +: 8];
            default: ;  // Garbler and evaluator inputs stay constant
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/gc_main.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gc_params.svh"

module gc_main (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`GC_CODE_WORDS*32-1:0]  i_code_init,
  input  logic [`GC_G_WORDS*32-1:0]     i_g_init,
  input  logic [`GC_E_WORDS*32-1:0]     i_e_init,
  output logic [`GC_OUT_WORDS*32-1:0]   o_out,
  output logic                          o_terminate
);

  import gc_pkg::*;

  mem_req_t mem_req;
  word_t    mem_rdata;

  gc_core u_gc_core (
    .clk         (clk),
    .rst         (rst),
    .o_req       (mem_req),
    .i_rdata     (mem_rdata),
    .o_terminate (o_terminate)
  );

  gc_mem_map u_gc_mem_map (
    .clk         (clk),
    .rst         (rst),
    .i_code_init (i_code_init),
    .i_g_init    (i_g_init),
    .i_e_init    (i_e_init),
    .i_req       (mem_req),
    .o_rdata     (mem_rdata),
    .o_out       (o_out)
  );

endmodule

`default_nettype wire

/* testbench/gc_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module gc_core_props (
  input logic                clk,
  input logic                rst,
  input gc_pkg::mem_req_t    i_req,
  input gc_pkg::core_state_e i_state,
  input logic                i_terminate
);

  import gc_pkg::*;

  int violations = 0;

  a_legal_be: assert property (@(posedge clk) disable iff (rst)
    i_req.we |-> (i_req.be == 4'b1111 || $onehot(i_req.be)))
    else begin
      violations++;
      $error("store with illegal byte enable %b", i_req.be);
    end

  a_terminate_sticky: assert property (@(posedge clk) disable iff (rst)
    !$fell(i_terminate))
    else begin
      violations++;
      $error("o_terminate fell while reset was low");
    end

  a_no_fetch_write: assert property (@(posedge clk) disable iff (rst)
    (i_state == FETCH) |-> !i_req.we)
    else begin
      violations++;
      $error("write enable set during FETCH");
    end

endmodule

bind gc_core gc_core_props u_gc_core_props (
  .clk         (clk),
  .rst         (rst),
  .i_req       (o_req),
  .i_state     (state),
  .i_terminate (o_terminate)
);

`default_nettype wire

/* testbench/gc_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gc_params.svh"

module gc_checker (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`GC_G_WORDS*32-1:0]   i_g_init,
  input  logic [`GC_E_WORDS*32-1:0]   i_e_init,
  input  logic [`GC_OUT_WORDS*32-1:0] i_out,
  input  logic                        i_terminate,
  output logic                        o_done,
  output logic [31:0]                 o_fail_count
);

  import gc_pkg::*;

  logic [`GC_OUT_WORDS*32-1:0] exp_out;
  int   tests_run;
  int   tests_failed;
  logic seen_halt;
  logic term_dropped;

  // Expected output region from the garbler and evaluator words
  function automatic logic [`GC_OUT_WORDS*32-1:0] expected_out(
    input logic [`GC_G_WORDS*32-1:0] g,
    input logic [`GC_E_WORDS*32-1:0] e
  );
    logic [`GC_OUT_WORDS*32-1:0] r;
    word_t g0;
    word_t e0;
    r  = '0;
    g0 = g[31:0];
    e0 = e[31:0];
    for (int k = 0; k < 8; k++)
      r[32*k +: 32] = g[32*k +: 32] ^ e[32*k +: 32];
    r[32*8 +: 32]  = g0 + e0;
    r[32*9 +: 32]  = g0 - e0;
    r[32*10 +: 32] = g0 & e0;
    r[32*11 +: 32] = g0 | e0;
    r[32*12 +: 32] = {g[103:96], g[71:64], g[39:32], g[7:0]};  // Low bytes of g3..g0
    r[32*13 +: 32] = g0;        // Garbler region is read-only
    r[32*14 +: 32] = e[63:32];  // e1 through the stack
    return r;
  endfunction

  task automatic check_range(input string name, input int first, input int last,
                             input logic cond_ok, input string cond_msg);
    logic ok;
    ok = cond_ok;
    if (!cond_ok)
      $display("ERROR %s: %s", name, cond_msg);
    for (int k = first; k <= last; k++) begin
      if (i_out[32*k +: 32] !== exp_out[32*k +: 32]) begin
        $display("FAILED %s: out word %0d expected %h, actual %h",
                 name, k, exp_out[32*k +: 32], i_out[32*k +: 32]);
        ok = 1'b0;
      end
    end
    tests_run++;
    if (ok) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: did not pass", name);
    end
  endtask

  always @(negedge clk or posedge rst) begin
    if (rst) begin
      seen_halt    <= 1'b0;
      term_dropped <= 1'b0;
    end else begin
      if (i_terminate)
        seen_halt <= 1'b1;
      if (seen_halt && !i_terminate)
        term_dropped <= 1'b1;
    end
  end

  initial begin
    o_done       = 1'b0;
    o_fail_count = '0;
    tests_run    = 0;
    tests_failed = 0;
    exp_out      = '0;
    @(negedge rst);
    @(negedge clk);
    check_range("reset_state", 0, `GC_OUT_WORDS - 1, i_terminate === 1'b0,
                "o_terminate is not low after reset");
    wait (i_terminate === 1'b1);
    repeat (4) @(negedge clk);  // Halted state must hold
    exp_out = expected_out(i_g_init, i_e_init);
    check_range("xor_loop", 0, 7, 1'b1, "");
    check_range("alu_ops", 8, 11, 1'b1, "");
    check_range("byte_stores", 12, 12, 1'b1, "");
    check_range("protect_and_stack", 13, 14, 1'b1, "");
    check_range("termination", 15, `GC_OUT_WORDS - 1,
                i_terminate === 1'b1 && !term_dropped,
                "o_terminate did not stay high after HALT");
    $display("tests run: %0d, passed: %0d, failed: %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    o_fail_count = tests_failed;
    o_done       = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/gc_main_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gc_params.svh"

module gc_main_tb;

  import gc_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 10;
  localparam int LOOP_COUNT     = 8;
  localparam int EXEC_INSTRS    = 4 + 9*LOOP_COUNT + 29;  // Setup, loop body, tail
  localparam int TIMEOUT_CYCLES = 2*EXEC_INSTRS*2 + RESET_CYCLES;

  logic                        clk;
  logic                        rst;
  logic [`GC_CODE_WORDS*32-1:0] code_init;
  logic [`GC_G_WORDS*32-1:0]    g_init;
  logic [`GC_E_WORDS*32-1:0]    e_init;
  logic [`GC_OUT_WORDS*32-1:0]  out_vec;
  logic                         terminate;
  logic                         check_done;
  logic [31:0]                  check_fails;
  logic [`GC_CODE_WORDS*32-1:0] code_image;
  logic [`GC_G_WORDS*32-1:0]    g_image;
  logic [`GC_E_WORDS*32-1:0]    e_image;
  logic [31:0]                  lfsr;
  int                           cycle_count;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  task automatic random_word(output word_t w);
    for (int b = 0; b < 32; b++) begin
      lfsr = lfsr_next(lfsr);
      w[b] = lfsr[0];
    end
  endtask

  // Stores use rs1 as base and rs2 as data
  function automatic word_t encode(input opcode_e op, input reg_idx_t rd, input reg_idx_t rs1,
                                   input reg_idx_t rs2, input logic [15:0] imm);
    return {op, rd, rs1, rs2, 3'b000, imm};
  endfunction

  task automatic build_images();
    word_t prog [$];
    word_t w;
    prog.push_back(encode(OP_LUI,  3'd1, 3'd0, 3'd0, 16'h0100));  // Garbler base
    prog.push_back(encode(OP_LUI,  3'd2, 3'd0, 3'd0, 16'h0200));  // Evaluator base
    prog.push_back(encode(OP_LUI,  3'd3, 3'd0, 3'd0, 16'h0300));  // Output base
    prog.push_back(encode(OP_ADDI, 3'd4, 3'd0, 3'd0, 16'(LOOP_COUNT)));
    prog.push_back(encode(OP_LDW,  3'd5, 3'd1, 3'd0, 16'h0000));  // Loop start
    prog.push_back(encode(OP_LDW,  3'd6, 3'd2, 3'd0, 16'h0000));
    prog.push_back(encode(OP_XOR,  3'd7, 3'd5, 3'd6, 16'h0000));
    prog.push_back(encode(OP_STW,  3'd0, 3'd3, 3'd7, 16'h0000));
    prog.push_back(encode(OP_ADDI, 3'd1, 3'd1, 3'd0, 16'h0004));
    prog.push_back(encode(OP_ADDI, 3'd2, 3'd2, 3'd0, 16'h0004));
    prog.push_back(encode(OP_ADDI, 3'd3, 3'd3, 3'd0, 16'h0004));
    prog.push_back(encode(OP_ADDI, 3'd4, 3'd4, 3'd0, 16'hffff));
    prog.push_back(encode(OP_BNE,  3'd0, 3'd4, 3'd0, 16'hfff7));  // Back 9 words
    prog.push_back(encode(OP_LUI,  3'd1, 3'd0, 3'd0, 16'h0100));
    prog.push_back(encode(OP_LUI,  3'd2, 3'd0, 3'd0, 16'h0200));
    prog.push_back(encode(OP_LDW,  3'd5, 3'd1, 3'd0, 16'h0000));
    prog.push_back(encode(OP_LDW,  3'd6, 3'd2, 3'd0, 16'h0000));
    prog.push_back(encode(OP_ADD,  3'd7, 3'd5, 3'd6, 16'h0000));
    prog.push_back(encode(OP_STW,  3'd0, 3'd3, 3'd7, 16'h0000));  // Out word 8
    prog.push_back(encode(OP_SUB,  3'd7, 3'd5, 3'd6, 16'h0000));
    prog.push_back(encode(OP_STW,  3'd0, 3'd3, 3'd7, 16'h0004));
    prog.push_back(encode(OP_AND,  3'd7, 3'd5, 3'd6, 16'h0000));
    prog.push_back(encode(OP_STW,  3'd0, 3'd3, 3'd7, 16'h0008));
    prog.push_back(encode(OP_OR,   3'd7, 3'd5, 3'd6, 16'h0000));
    prog.push_back(encode(OP_STW,  3'd0, 3'd3, 3'd7, 16'h000c));
    prog.push_back(encode(OP_STB,  3'd0, 3'd3, 3'd5, 16'h0010));  // Out word 12 lanes
    prog.push_back(encode(OP_LDW,  3'd5, 3'd1, 3'd0, 16'h0004));
    prog.push_back(encode(OP_STB,  3'd0, 3'd3, 3'd5, 16'h0011));
    prog.push_back(encode(OP_LDW,  3'd5, 3'd1, 3'd0, 16'h0008));
    prog.push_back(encode(OP_STB,  3'd0, 3'd3, 3'd5, 16'h0012));
    prog.push_back(encode(OP_LDW,  3'd5, 3'd1, 3'd0, 16'h000c));
    prog.push_back(encode(OP_STB,  3'd0, 3'd3, 3'd5, 16'h0013));
    prog.push_back(encode(OP_ADDI, 3'd7, 3'd0, 3'd0, 16'h05a5));
    prog.push_back(encode(OP_STW,  3'd0, 3'd1, 3'd7, 16'h0000));  // Dropped write
    prog.push_back(encode(OP_LDW,  3'd5, 3'd1, 3'd0, 16'h0000));
    prog.push_back(encode(OP_STW,  3'd0, 3'd3, 3'd5, 16'h0014));
    prog.push_back(encode(OP_LUI,  3'd4, 3'd0, 3'd0, 16'h0400));  // Stack base
    prog.push_back(encode(OP_LDW,  3'd6, 3'd2, 3'd0, 16'h0004));
    prog.push_back(encode(OP_STW,  3'd0, 3'd4, 3'd6, 16'h0014));
    prog.push_back(encode(OP_LDW,  3'd5, 3'd4, 3'd0, 16'h0014));
    prog.push_back(encode(OP_STW,  3'd0, 3'd3, 3'd5, 16'h0018));
    prog.push_back(encode(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
    for (int i = 0; i < `GC_CODE_WORDS; i++) begin
      if (i < prog.size())
        code_image[32*i +: 32] = prog[i];
      else
        code_image[32*i +: 32] = {4'hb, 12'h000, 16'(i)};  // HALT tagged with its index
    end
    for (int i = 0; i < `GC_G_WORDS; i++) begin
      random_word(w);
      g_image[32*i +: 32] = w;
    end
    for (int i = 0; i < `GC_E_WORDS; i++) begin
      random_word(w);
      e_image[32*i +: 32] = w;
    end
  endtask

  gc_main u_gc_main (
    .clk         (clk),
    .rst         (rst),
    .i_code_init (code_init),
    .i_g_init    (g_init),
    .i_e_init    (e_init),
    .o_out       (out_vec),
    .o_terminate (terminate)
  );

  gc_checker u_gc_checker (
    .clk          (clk),
    .rst          (rst),
    .i_g_init     (g_init),
    .i_e_init     (e_init),
    .i_out        (out_vec),
    .i_terminate  (terminate),
    .o_done       (check_done),
    .o_fail_count (check_fails)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    lfsr = 32'hc8;
    build_images();
    rst       <= 1'b1;
    code_init <= code_image;
    g_init    <= g_image;
    e_init    <= e_image;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("ERROR: o_terminate did not rise within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    wait (check_done === 1'b1);
    if (check_fails == 0 && u_gc_main.u_gc_core.u_gc_core_props.violations == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("%0d assertion violations in the core",
               u_gc_main.u_gc_core.u_gc_core_props.violations);
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
src/gc_pkg.sv
src/gc_decode.sv
src/gc_execute.sv
src/gc_result.sv
src/gc_core.sv
src/gc_mem_map.sv
src/gc_main.sv
testbench/gc_core_props.sv
testbench/gc_checker.sv
testbench/gc_main_tb.sv
